// File: rtl/color_pkg.sv
`default_nettype none

package color_pkg;

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } color12_t;

    // Driven whenever the beam is outside the active area
    localparam color12_t COLOR_BLACK = '{red: 4'h0, green: 4'h0, blue: 4'h0};

endpackage

`default_nettype wire

// File: rtl/video_pkg.sv
`default_nettype none

package video_pkg;

    // Raster geometry, all lengths in pixels or lines
    typedef struct packed {
        logic [15:0] h_active;
        logic [15:0] h_front;
        logic [15:0] h_sync;
        logic [15:0] h_back;
        logic [15:0] v_active;
        logic [15:0] v_front;
        logic [15:0] v_sync;
        logic [15:0] v_back;
        logic        sync_pol;  // 1 = sync pulses high
    } raster_timing_t;

    // Standard 640x480 at 60 Hz, negative sync
    localparam raster_timing_t VGA_640X480 = '{
        h_active: 16'd640,
        h_front:  16'd16,
        h_sync:   16'd96,
        h_back:   16'd48,
        v_active: 16'd480,
        v_front:  16'd10,
        v_sync:   16'd2,
        v_back:   16'd33,
        sync_pol: 1'b0
    };

    // Current beam position with decoded levels
    typedef struct packed {
        logic [15:0] h;
        logic [15:0] v;
        logic        active;
        logic        hsync;   // Already at the configured polarity
        logic        vsync;
    } scan_pos_t;

    typedef struct packed {
        logic                hsync;
        logic                vsync;
        logic                active;
        color_pkg::color12_t color;
    } video_out_t;

endpackage

`default_nettype wire

// File: rtl/dual_clock_bram.sv
`default_nettype none
`timescale 1ns/100ps

// Simple dual-port RAM, write on one clock and read on another
module dual_clock_bram #(
    parameter type PAYLOAD_T = logic [15:0],
    parameter int  DEPTH     = 1024
) (
    input  wire logic                     clk_write,
    input  wire logic                     write_enable,
    input  wire logic [$clog2(DEPTH)-1:0] write_addr,
    input  wire PAYLOAD_T                 write_data,

    input  wire logic                     clk_read,
    input  wire logic [$clog2(DEPTH)-1:0] read_addr,
    output PAYLOAD_T                      read_data
);

    PAYLOAD_T mem [DEPTH];  // No init, contents come from the writer

    always_ff @(posedge clk_write) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // Registered read, old contents win on a collision
    always_ff @(posedge clk_read) begin
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

// File: rtl/double_framebuffer.sv
`default_nettype none
`timescale 1ns/100ps

module double_framebuffer #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120
) (
    input  wire logic                          clk_write,
    input  wire logic                          clk_read,
    input  wire logic                          rst,
    input  wire logic                          swap,       // One-cycle request on clk_read
    input  wire logic                          frame_end,  // Last cycle of the frame

    input  wire logic                          write_enable,
    input  wire logic [$clog2(FB_WIDTH)-1:0]   write_x,
    input  wire logic [$clog2(FB_HEIGHT)-1:0]  write_y,
    input  wire color_pkg::color12_t           write_data,

    input  wire logic [$clog2(FB_WIDTH)-1:0]   read_x,
    input  wire logic [$clog2(FB_HEIGHT)-1:0]  read_y,
    output color_pkg::color12_t                read_data
);

    localparam int FB_DEPTH = FB_WIDTH * FB_HEIGHT;
    localparam int ADDR_W   = $clog2(FB_DEPTH);

    typedef enum logic {FB_A, FB_B} fb_select_t;

    logic [ADDR_W-1:0]   write_addr;
    logic [ADDR_W-1:0]   read_addr;
    fb_select_t          read_select;
    fb_select_t          write_select;
    logic                swap_pending;
    color_pkg::color12_t read_data_a;
    color_pkg::color12_t read_data_b;

    // Row-major linear addresses
    assign write_addr = ADDR_W'(32'(write_y) * FB_WIDTH + 32'(write_x));
    assign read_addr  = ADDR_W'(32'(read_y) * FB_WIDTH + 32'(read_x));

    // Swap waits for the frame boundary so a frame never mixes buffers
    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            read_select  <= FB_A;
            write_select <= FB_B;
            swap_pending <= 1'b0;
        end else begin
            if (swap_pending && frame_end) begin
                read_select  <= (read_select == FB_A) ? FB_B : FB_A;
                write_select <= (write_select == FB_A) ? FB_B : FB_A;
            end
            swap_pending <= swap || (swap_pending && !frame_end);
        end
    end

    // write_select is sampled unsynchronised on clk_write,
    // the renderer keeps quiet around a swap
    dual_clock_bram #(
        .PAYLOAD_T (color_pkg::color12_t),
        .DEPTH     (FB_DEPTH)
    ) framebuffer_a (
        .clk_write    (clk_write),
        .write_enable (write_enable && (write_select == FB_A)),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .clk_read     (clk_read),
        .read_addr    (read_addr),
        .read_data    (read_data_a)
    );

    dual_clock_bram #(
        .PAYLOAD_T (color_pkg::color12_t),
        .DEPTH     (FB_DEPTH)
    ) framebuffer_b (
        .clk_write    (clk_write),
        .write_enable (write_enable && (write_select == FB_B)),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .clk_read     (clk_read),
        .read_addr    (read_addr),
        .read_data    (read_data_b)
    );

    // Output mux adds one cycle of latency
    always_ff @(posedge clk_read) begin
        read_data <= (read_select == FB_A) ? read_data_a : read_data_b;
    end

endmodule

`default_nettype wire

// File: rtl/scan_timing.sv
`default_nettype none
`timescale 1ns/100ps

module scan_timing #(
    parameter video_pkg::raster_timing_t TIMING = video_pkg::VGA_640X480
) (
    input  wire logic            clk_read,
    input  wire logic            rst,
    output video_pkg::scan_pos_t pos,
    output logic                 frame_end
);

    // Line layout is active, front porch, sync, back porch
    localparam logic [15:0] H_SYNC_START = TIMING.h_active + TIMING.h_front;
    localparam logic [15:0] H_SYNC_END   = H_SYNC_START + TIMING.h_sync;
    localparam logic [15:0] H_TOTAL      = H_SYNC_END + TIMING.h_back;

    localparam logic [15:0] V_SYNC_START = TIMING.v_active + TIMING.v_front;
    localparam logic [15:0] V_SYNC_END   = V_SYNC_START + TIMING.v_sync;
    localparam logic [15:0] V_TOTAL      = V_SYNC_END + TIMING.v_back;

    logic [15:0] h_count;
    logic [15:0] v_count;
    logic        line_end;
    logic        in_hsync;
    logic        in_vsync;

    assign line_end = (h_count == H_TOTAL - 16'd1);

    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (line_end) begin
                h_count <= '0;
                if (v_count == V_TOTAL - 16'd1) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 16'd1;
                end
            end else begin
                h_count <= h_count + 16'd1;
            end
        end
    end

    assign in_hsync = (h_count >= H_SYNC_START) && (h_count < H_SYNC_END);
    assign in_vsync = (v_count >= V_SYNC_START) && (v_count < V_SYNC_END);

    always_comb begin
        pos.h      = h_count;
        pos.v      = v_count;
        pos.active = (h_count < TIMING.h_active) && (v_count < TIMING.v_active);
        // Polarity bit is the asserted level
        pos.hsync  = in_hsync ? TIMING.sync_pol : ~TIMING.sync_pol;
        pos.vsync  = in_vsync ? TIMING.sync_pol : ~TIMING.sync_pol;
    end

    // Final blanking cycle before (0,0)
    assign frame_end = line_end && (v_count == V_TOTAL - 16'd1);

endmodule

`default_nettype wire

// File: rtl/pixel_fetch.sv
`default_nettype none
`timescale 1ns/100ps

module pixel_fetch #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int SCALE     = 4
) (
    input  wire logic                         clk_read,
    input  wire logic                         rst,
    input  wire video_pkg::scan_pos_t         pos,
    output logic [$clog2(FB_WIDTH)-1:0]       read_x,
    output logic [$clog2(FB_HEIGHT)-1:0]      read_y,
    input  wire color_pkg::color12_t          read_data,
    output video_pkg::video_out_t             video
);

    localparam logic [15:0] X_MAX = 16'(FB_WIDTH - 1);
    localparam logic [15:0] Y_MAX = 16'(FB_HEIGHT - 1);

    logic [15:0] fb_x;
    logic [15:0] fb_y;
    logic [2:0]  hsync_pipe;  // Index 2 lines up with read_data
    logic [2:0]  vsync_pipe;
    logic [2:0]  active_pipe;

    // Divide down to stored pixels, clamp blanking positions into the buffer
    always_comb begin
        fb_x = pos.h / 16'(SCALE);
        fb_y = pos.v / 16'(SCALE);
        if (fb_x > X_MAX) begin
            fb_x = X_MAX;
        end
        if (fb_y > Y_MAX) begin
            fb_y = Y_MAX;
        end
    end

    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            read_x      <= '0;
            read_y      <= '0;
            active_pipe <= '0;
        end else begin
            read_x      <= fb_x[$clog2(FB_WIDTH)-1:0];
            read_y      <= fb_y[$clog2(FB_HEIGHT)-1:0];
            active_pipe <= {active_pipe[1:0], pos.active};
        end
    end

    // Sync levels flush to the idle level of (0,0) while reset holds the scan there
    always_ff @(posedge clk_read) begin
        hsync_pipe <= {hsync_pipe[1:0], pos.hsync};
        vsync_pipe <= {vsync_pipe[1:0], pos.vsync};
    end

    always_comb begin
        video.hsync  = hsync_pipe[2];
        video.vsync  = vsync_pipe[2];
        video.active = active_pipe[2];
        video.color  = active_pipe[2] ? read_data : color_pkg::COLOR_BLACK;
    end

endmodule

`default_nettype wire

// File: rtl/display_top.sv
`default_nettype none
`timescale 1ns/100ps

module display_top #(
    parameter int                        FB_WIDTH  = 160,
    parameter int                        FB_HEIGHT = 120,
    parameter int                        SCALE     = 4,
    parameter video_pkg::raster_timing_t TIMING    = video_pkg::VGA_640X480
) (
    input  wire logic                          clk_write,
    input  wire logic                          clk_read,
    input  wire logic                          rst,
    input  wire logic                          swap,

    // Renderer port, clk_write domain
    input  wire logic                          write_enable,
    input  wire logic [$clog2(FB_WIDTH)-1:0]   write_x,
    input  wire logic [$clog2(FB_HEIGHT)-1:0]  write_y,
    input  wire color_pkg::color12_t           write_data,

    output video_pkg::video_out_t              video  // 3 cycles behind the scan
);

    video_pkg::scan_pos_t             pos;
    logic                             frame_end;
    logic [$clog2(FB_WIDTH)-1:0]      read_x;
    logic [$clog2(FB_HEIGHT)-1:0]     read_y;
    color_pkg::color12_t              read_data;

    scan_timing #(
        .TIMING (TIMING)
    ) i_scan_timing (
        .clk_read  (clk_read),
        .rst       (rst),
        .pos       (pos),
        .frame_end (frame_end)
    );

    pixel_fetch #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .SCALE     (SCALE)
    ) i_pixel_fetch (
        .clk_read  (clk_read),
        .rst       (rst),
        .pos       (pos),
        .read_x    (read_x),
        .read_y    (read_y),
        .read_data (read_data),
        .video     (video)
    );

    double_framebuffer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) i_double_framebuffer (
        .clk_write    (clk_write),
        .clk_read     (clk_read),
        .rst          (rst),
        .swap         (swap),
        .frame_end    (frame_end),
        .write_enable (write_enable),
        .write_x      (write_x),
        .write_y      (write_y),
        .write_data   (write_data),
        .read_x       (read_x),
        .read_y       (read_y),
        .read_data    (read_data)
    );

endmodule

`default_nettype wire

// File: sim/display_checker.sv
`default_nettype none
`timescale 1ns/100ps

module display_checker #(
    parameter video_pkg::raster_timing_t TIMING = video_pkg::VGA_640X480
) (
    input  wire logic                  clk_read,
    input  wire logic                  rst,
    input  wire video_pkg::video_out_t video,
    input  wire logic                  frame_end,
    input  wire logic                  read_select
);

    localparam logic [15:0] H_SYNC_WIDTH = TIMING.h_sync;

    logic        hsync_on;
    logic [15:0] hsync_len;  // Length of the pulse so far

    assign hsync_on = (video.hsync == TIMING.sync_pol);

    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            hsync_len <= '0;
        end else if (hsync_on) begin
            hsync_len <= hsync_len + 16'd1;
        end else begin
            hsync_len <= '0;
        end
    end

    blank_is_black: assert property (
        @(posedge clk_read) disable iff (rst)
        !video.active |-> video.color == color_pkg::COLOR_BLACK
    ) else $error("colour is not black outside the active area");

    // Pulse ends right on the configured width
    hsync_width: assert property (
        @(posedge clk_read) disable iff (rst)
        $fell(hsync_on) |-> hsync_len == H_SYNC_WIDTH
    ) else $error("hsync pulse width differs from the raster timing");

    hsync_not_stuck: assert property (
        @(posedge clk_read) disable iff (rst)
        hsync_on |-> hsync_len < H_SYNC_WIDTH
    ) else $error("hsync pulse runs past the raster timing");

    select_at_frame_end: assert property (
        @(posedge clk_read) disable iff (rst)
        !frame_end |=> $stable(read_select)
    ) else $error("read buffer changed away from the frame boundary");

endmodule

bind display_top display_checker #(
    .TIMING (TIMING)
) i_display_checker (
    .clk_read    (clk_read),
    .rst         (rst),
    .video       (video),
    .frame_end   (frame_end),
    .read_select (i_double_framebuffer.read_select)
);

`default_nettype wire

// File: sim/tb_display_top.sv
`default_nettype none
`timescale 1ns/100ps

module tb_display_top;

    localparam int FB_W       = 8;
    localparam int FB_H       = 6;
    localparam int SCALE      = 2;
    localparam int H_TOTAL    = 24;  // 16 + 2 + 3 + 3
    localparam int V_TOTAL    = 16;  // 12 + 1 + 2 + 1
    localparam int WAIT_LIMIT = 2 * H_TOTAL * V_TOTAL;
    localparam logic [31:0] SEED = 32'had71f8ca;

    // Active, front, sync and back for h then v with negative sync
    localparam video_pkg::raster_timing_t TB_TIMING =
        '{16'd16, 16'd2, 16'd3, 16'd3, 16'd12, 16'd1, 16'd2, 16'd1, 1'b0};

    logic                  clk_read     = 1'b0;
    logic                  clk_write    = 1'b0;
    logic                  rst          = 1'b1;
    logic                  swap         = 1'b0;
    logic                  write_enable = 1'b0;
    logic [2:0]            write_x      = '0;
    logic [2:0]            write_y      = '0;
    color_pkg::color12_t   write_data   = '0;
    video_pkg::video_out_t video;

    int buffer_image [2] = '{-1, -1};  // Image id held by A and B or -1 while empty
    int shown_buffer     = 0;          // Expected read select
    bit swap_requested   = 1'b0;
    bit run_over         = 1'b0;
    int pixels_checked   = 0;

    always #50 clk_read = ~clk_read;
    always #65 clk_write = ~clk_write;

    display_top #(
        .FB_WIDTH  (FB_W),
        .FB_HEIGHT (FB_H),
        .SCALE     (SCALE),
        .TIMING    (TB_TIMING)
    ) i_display_top (
        .clk_write    (clk_write),
        .clk_read     (clk_read),
        .rst          (rst),
        .swap         (swap),
        .write_enable (write_enable),
        .write_x      (write_x),
        .write_y      (write_y),
        .write_data   (write_data),
        .video        (video)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // Stored pixel of an image from 12 LFSR bits per pixel in raster order
    function automatic color_pkg::color12_t image_pixel(input int image_id, input int x,
                                                        input int y);
        logic [31:0] state;
        logic [11:0] bits;
        int          skip;
        state = SEED ^ (image_id * 32'h9e37_79b9);
        if (state == 32'h0) begin
            state = SEED;
        end
        bits = '0;
        skip = (y * FB_W + x) * 12;
        for (int i = 0; i < skip; i++) begin
            state = lfsr_step(state);
        end
        for (int i = 0; i < 12; i++) begin
            bits  = {bits[10:0], state[0]};
            state = lfsr_step(state);
        end
        return color_pkg::color12_t'(bits);
    endfunction

    // Expected levels for the scan position behind this output
    // A negative index means the pipeline still holds reset state
    function automatic video_pkg::video_out_t expected_levels(input int scan_index);
        video_pkg::video_out_t want;
        int                    h;
        int                    v;
        want       = '0;
        want.hsync = ~TB_TIMING.sync_pol;
        want.vsync = ~TB_TIMING.sync_pol;
        if (scan_index >= 0) begin
            h           = scan_index % H_TOTAL;
            v           = (scan_index / H_TOTAL) % V_TOTAL;
            want.active = (h < 16) && (v < 12);
            if (h >= 18 && h < 21) begin
                want.hsync = TB_TIMING.sync_pol;
            end
            if (v >= 13 && v < 15) begin
                want.vsync = TB_TIMING.sync_pol;
            end
        end
        return want;
    endfunction

    task automatic end_with_failure();
        run_over = 1'b1;
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_sync(input video_pkg::video_out_t got,
                              input video_pkg::video_out_t want);
        if (got.hsync !== want.hsync || got.vsync !== want.vsync
                || got.active !== want.active) begin
            $display("error at %0t ns: hsync vsync active %b %b %b, expected %b %b %b", $time,
                     got.hsync, got.vsync, got.active, want.hsync, want.vsync, want.active);
            end_with_failure();
        end
    endtask

    task automatic check_color(input color_pkg::color12_t got, input color_pkg::color12_t want,
                               input string where);
        if (got !== want) begin
            $display("error at %0t ns: colour %h at %s, expected %h", $time, got, where, want);
            end_with_failure();
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        if (got != want) begin
            $display("error at %0t ns: %0d %s, expected %0d", $time, got, what, want);
            end_with_failure();
        end
    endtask

    task automatic wait_vsync_start();
        bit was_on;
        was_on = (video.vsync == TB_TIMING.sync_pol);
        for (int i = 0; i <= WAIT_LIMIT; i++) begin
            @(negedge clk_read);
            if (video.vsync == TB_TIMING.sync_pol && !was_on) begin
                return;
            end
            was_on = (video.vsync == TB_TIMING.sync_pol);
        end
        $display("timeout: the vsync pulse never started");
        end_with_failure();
    endtask

    task automatic wait_active_start();
        for (int i = 0; i <= WAIT_LIMIT; i++) begin
            @(negedge clk_read);
            if (video.active) begin
                return;
            end
        end
        $display("timeout: no active pixel appeared on the video output");
        end_with_failure();
    endtask

    task automatic wait_frame_start();
        wait_vsync_start();
        wait_active_start();
    endtask

    // Pulse swap around line 5 of the frame on screen
    task automatic request_swap();
        wait_active_start();
        repeat (5 * H_TOTAL) @(posedge clk_read);
        #10 swap = 1'b1;
        swap_requested = 1'b1;
        @(posedge clk_read);
        #10 swap = 1'b0;
    endtask

    task automatic write_image(input int image_id);
        int target;
        target = 1 - shown_buffer;  // Write side is the buffer off screen
        for (int y = 0; y < FB_H; y++) begin
            for (int x = 0; x < FB_W; x++) begin
                @(posedge clk_write);
                #10;
                write_enable = 1'b1;
                write_x      = 3'(x);
                write_y      = 3'(y);
                write_data   = image_pixel(image_id, x, y);
            end
        end
        @(posedge clk_write);
        #10 write_enable = 1'b0;
        buffer_image[target] = image_id;
    endtask

    initial begin : capture
        int                    cycle;
        int                    px;
        int                    line;
        bit                    was_active;
        bit                    was_vsync;
        bit                    vsync_on;
        color_pkg::color12_t   want_color;
        cycle      = 0;
        px         = 0;
        line       = 0;
        was_active = 1'b0;
        was_vsync  = 1'b0;
        for (int i = 0; rst; i++) begin
            if (i > 20) begin
                $display("timeout: reset was never released");
                end_with_failure();
            end
            @(negedge clk_read);
        end
        forever begin
            check_sync(video, expected_levels(cycle - 3));  // Output trails the scan by 3
            vsync_on = (video.vsync == TB_TIMING.sync_pol);
            if (vsync_on && !was_vsync) begin
                check_count(line, 12, "active lines in frame");
                line = 0;
                if (swap_requested) begin  // Takes effect at the coming frame end
                    shown_buffer   = 1 - shown_buffer;
                    swap_requested = 1'b0;
                end
            end
            if (video.active) begin
                if (buffer_image[shown_buffer] >= 0) begin
                    want_color = image_pixel(buffer_image[shown_buffer], px / SCALE, line / SCALE);
                    check_color(video.color, want_color, $sformatf("(%0d,%0d)", px, line));
                    pixels_checked++;
                end
                px++;
            end else begin
                check_color(video.color, color_pkg::COLOR_BLACK, "blanking");
                if (was_active) begin
                    check_count(px, 16, "active pixels in line");
                    px = 0;
                    line++;
                end
            end
            was_active = video.active;
            was_vsync  = vsync_on;
            cycle++;
            @(negedge clk_read);
        end
    end

    initial begin : stimulus
        repeat (5) @(posedge clk_read);
        #10 rst = 1'b0;
        write_image(1);      // B
        request_swap();
        wait_frame_start();  // B on screen
        write_image(0);      // A
        request_swap();
        wait_frame_start();  // Back to A
        wait_frame_start();
        write_image(2);      // B changes while A is shown
        wait_frame_start();
        request_swap();      // Rest of this frame stays on image 0
        wait_frame_start();
        wait_frame_start();
        write_image(3);
        request_swap();
        wait_frame_start();
        wait_frame_start();
        if (pixels_checked == 0) begin
            $display("no active pixel was ever compared against an image");
            end_with_failure();
        end else begin
            run_over = 1'b1;
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    final begin
        if (!run_over) begin
            $display("simulation stopped before the test sequence finished");
            $display("CHECKS FAILED");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/color_pkg.sv
rtl/video_pkg.sv
rtl/dual_clock_bram.sv
rtl/double_framebuffer.sv
rtl/scan_timing.sv
rtl/pixel_fetch.sv
rtl/display_top.sv
sim/display_checker.sv
sim/tb_display_top.sv

// File: Makefile
TOP     := tb_display_top
SOURCES := $(wildcard rtl/*.sv sim/*.sv)

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f tb.f --top-module $(TOP)

obj_dir/V$(TOP): tb.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -qx "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
